// File: compile.f
+incdir+include
design/corePkg.sv
design/fetchBuffer.sv
design/instDecoder.sv
design/pipeControl.sv
design/regFile.sv
design/aluStage.sv
design/coreTop.sv
verif/clockGen.sv
verif/memoryModel.sv
verif/coreTb.sv

// File: Makefile
# Verilator build for the core testbench; override variables on the command line
VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= coreTb
RTL_TOP   ?= coreTop
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/coreTb.sv
// each test reloads memory and resets the core; a run is capped at 400 cycles per test
module coreTb;
   import corePkg::*;

   localparam int TestCount = 6;
   localparam int CycleLimit = TestCount * 400;

   logic bus, powerReset, testReset, reset, reqAck, respAck, halted;
   addr_t entry;
   addr_t progEntry;
   busReq_t busReq;
   busResp_t busResp;
   retire_t retire;
   addr_t expRip[$];
   logic expWrite[$];
   regIdx_t expDest[$];
   word_t expValue[$];
   logic [7:0] progBytes[$];
   word_t modelRegs [RegCount];
   int errors = 0, checks = 0, cycleCount = 0, seed = 24139;

   assign reset = powerReset || testReset;

   clockGen #(.Period(40), .ResetCycles(5)) clk_i (.bus(bus), .reset(powerReset));
   memoryModel #(.AckDelay(2)) mem_i (.bus(bus), .reset(reset), .busReq(busReq),
      .reqAck(reqAck), .busResp(busResp));
   coreTop #(.BufferBytes(128)) dut_i (.bus(bus), .reset(reset), .entry(entry),
      .busReq(busReq), .reqAck(reqAck), .busResp(busResp), .respAck(respAck),
      .retire(retire), .halted(halted));

   always @(posedge bus) begin
      cycleCount++;
      if (cycleCount >= CycleLimit) begin
         $display("timeout: core did not halt within %0d cycles", CycleLimit);
         $display("Done: errors found");
         $finish;
      end
   end

   task automatic startProgram(input addr_t entryAddr);
      progEntry = entryAddr;   // driven onto entry at the next reset
      progBytes.delete();
      expRip.delete();
      expWrite.delete();
      expDest.delete();
      expValue.delete();
      for (int r = 0; r < RegCount; r++) modelRegs[r] = '0;
   endtask

   task automatic expectRetire(input logic write, input int dest, input word_t value);
      expRip.push_back(progEntry + addr_t'(progBytes.size()));
      expWrite.push_back(write);
      expDest.push_back(regIdx_t'(dest));
      expValue.push_back(value);
   endtask

   task automatic addNop();
      expectRetire(1'b0, 0, '0);
      progBytes.push_back(8'h90);
   endtask

   task automatic addMov(input int dest, input word_t imm);
      expectRetire(1'b1, dest, imm);
      modelRegs[dest] = imm;
      progBytes.push_back(8'h48 | 8'(dest >> 3));   // REX.W, B for r8..r15
      progBytes.push_back(8'hB8 | 8'(dest & 7));
      for (int b = 0; b < 8; b++) progBytes.push_back(imm[b*8 +: 8]);
   endtask

   task automatic addAlu(input logic isSub, input int dest, input int src);
      word_t value;
      value = isSub ? modelRegs[dest] - modelRegs[src] : modelRegs[dest] + modelRegs[src];
      expectRetire(1'b1, dest, value);
      modelRegs[dest] = value;
      progBytes.push_back(8'h48 | 8'((src >> 3) << 2) | 8'(dest >> 3));
      progBytes.push_back(isSub ? 8'h29 : 8'h01);
      progBytes.push_back(8'hC0 | 8'((src & 7) << 3) | 8'(dest & 7));   // mod 11
   endtask

   task automatic checkValue(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic runProgram(input int num, input string name);
      int got;
      int startErrors;
      addr_t expReqAddr;
      logic prevCyc;
      startErrors = errors;
      got = 0;
      expReqAddr = progEntry - progEntry % addr_t'(LineBytes);   // line holding entry
      prevCyc = 1'b0;
      progBytes.push_back(8'hF4);   // HLT
      @(posedge bus);
      #2 testReset = 1'b1;
      entry = progEntry;
      foreach (progBytes[i]) mem_i.storage[13'(progEntry + addr_t'(i))] = progBytes[i];
      repeat (5) @(posedge bus);
      #2 testReset = 1'b0;
      while (!halted) begin
         @(posedge bus);
         #1;
         checkValue("respAck", word_t'(respAck), word_t'(busResp.cyc));
         if (busReq.cyc && !prevCyc) begin
            checkValue("busReq.addr", busReq.addr, expReqAddr);
            expReqAddr = expReqAddr + addr_t'(LineBytes);
         end
         prevCyc = busReq.cyc;
         if (retire.valid) begin
            if (got >= expRip.size()) begin
               $display("extra retire at rip 0x%h", retire.rip);
               errors++;
            end else begin
               checkValue("retire.rip", retire.rip, expRip[got]);
               checkValue("retire.regWrite", word_t'(retire.regWrite), word_t'(expWrite[got]));
               if (expWrite[got]) begin
                  checkValue("retire.dest", word_t'(retire.dest), word_t'(expDest[got]));
                  checkValue("retire.value", retire.value, expValue[got]);
               end
            end
            got++;
         end
      end
      checks++;
      if (got != expRip.size()) begin
         $display("retired %0d instructions but expected %0d", got, expRip.size());
         errors++;
      end
      $display("test %0d %s: %s", num, name, errors == startErrors ? "ok" : "FAILED");
   endtask

   initial begin
      testReset = 1'b0;
      entry = 64'h1000;
      progEntry = 64'h1000;
      @(negedge powerReset);

      startProgram(64'h1000);
      addMov(0, 64'h0123_4567_89AB_CDEF);
      addMov(3, 64'hFFFF_0000_FFFF_0000);
      addMov(9, 64'h0000_0000_0000_0042);
      addMov(15, 64'h8000_0000_0000_0001);
      runProgram(1, "mov immediates");

      startProgram(64'h1100);
      addMov(1, 64'd100);
      addMov(2, 64'd7);
      addMov(10, 64'd3);
      addAlu(1'b0, 1, 2);
      addAlu(1'b0, 1, 1);
      addAlu(1'b1, 1, 2);
      addAlu(1'b1, 10, 1);   // goes below zero
      addAlu(1'b0, 2, 10);
      runProgram(2, "dependent add/sub");

      startProgram(64'h1200);
      addNop();
      addMov(4, 64'h11);
      addNop();
      addMov(11, 64'h22);
      addNop();
      addAlu(1'b0, 7, 5);
      runProgram(3, "rip steps");

      startProgram(64'h1300 + 13);
      addMov(2, 64'hDEAD_BEEF);
      addNop();
      addAlu(1'b0, 2, 2);
      runProgram(4, "unaligned entry");

      startProgram(64'h1400);
      for (int i = 0; i < 14; i++) begin
         addNop();
         addMov(i, word_t'(i + 1) * 64'h0101_0101_0101_0101);
      end
      runProgram(5, "buffer wrap");

      startProgram(64'h1600);
      for (int r = 0; r < 6; r++) addMov(r, {32'($random(seed)), 32'($random(seed))});
      addAlu(1'b0, 0, 1);
      addAlu(1'b1, 2, 3);
      addAlu(1'b0, 4, 0);
      addAlu(1'b1, 5, 2);
      addAlu(1'b0, 5, 4);
      runProgram(6, "random operands");

      $display("tests %0d, checks %0d, errors %0d", TestCount, checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end
endmodule

// File: verif/memoryModel.sv
// 8 KB byte store that wraps on address bits 12:0; one request is served at a time
module memoryModel #(
   parameter int AckDelay = 2
) (
   input  logic              bus,
   input  logic              reset,
   input  corePkg::busReq_t  busReq,
   output logic              reqAck,
   output corePkg::busResp_t busResp
);
   import corePkg::*;

   localparam int MemBytes = 8192;

   logic [7:0] storage [MemBytes];
   addr_t      lineAddr;
   int         waitCount;
   int         beat;
   int         phase;   // 0 idle, 1 ack delay, 2 beats

   initial begin
      reqAck = 1'b0;
      busResp = '0;
      phase = 0;
      for (int a = 0; a < MemBytes; a++) begin
         storage[a] = 8'(a ^ (a >> 8) ^ (a >> 5));   // filler changes with every address bit
      end
   end

   always @(posedge bus) begin
      #2;
      reqAck = 1'b0;
      busResp.cyc = 1'b0;
      if (reset) begin
         phase = 0;
      end else if (phase == 0 && busReq.cyc) begin
         lineAddr = busReq.addr;
         waitCount = AckDelay;
         phase = 1;
      end else if (phase == 1) begin
         waitCount = waitCount - 1;
         if (waitCount <= 1) begin
            reqAck = 1'b1;
            beat = 0;
            phase = 2;
         end
      end else if (phase == 2) begin
         busResp.cyc = 1'b1;
         for (int b = 0; b < BeatBytes; b++) begin
            busResp.data[b*8 +: 8] = storage[13'(lineAddr + addr_t'(beat * BeatBytes + b))];
         end
         beat = beat + 1;
         if (beat == LineBytes / BeatBytes) phase = 0;
      end
   end
endmodule

// File: verif/clockGen.sv
// reset is released 2 time units after the last reset edge; period must be even
module clockGen #(
   parameter int Period      = 40,
   parameter int ResetCycles = 5
) (
   output logic bus,
   output logic reset
);
   initial begin
      bus = 1'b0;
      forever #(Period / 2) bus = ~bus;
   end

   initial begin
      reset = 1'b1;
      repeat (ResetCycles) @(posedge bus);
      #2 reset = 1'b0;
   end
endmodule

// File: design/coreTop.sv
// entry is sampled while reset is high; BufferBytes below 128 lets a refill overrun the buffer
module coreTop #(
   parameter int BufferBytes = 128
) (
   input  logic              bus,
   input  logic              reset,
   input  corePkg::addr_t    entry,
   output corePkg::busReq_t  busReq,
   input  logic              reqAck,
   input  corePkg::busResp_t busResp,
   output logic              respAck,
   output corePkg::retire_t  retire,
   output logic              halted
);
   import corePkg::*;

   logic [MaxInstBytes*8-1:0] window;
   logic                      windowValid;
   logic                      advance;
   addr_t                     decRip;
   instLen_t                  byteCount;
   uop_t                      decUop;
   uop_t                      rdUop;
   uop_t                      exUop;
   word_t                     srcVal;
   word_t                     dstVal;

   fetchBuffer #(
      .BufferBytes(BufferBytes)
   ) fetchUnit (
      .bus(bus), .reset(reset), .entry(entry), .advance(advance), .byteCount(byteCount),
      .busReq(busReq), .reqAck(reqAck), .busResp(busResp), .respAck(respAck),
      .window(window), .windowValid(windowValid), .rip(decRip)
   );

   instDecoder decodeUnit (
      .window(window), .rip(decRip), .uop(decUop), .byteCount(byteCount)
   );

   pipeControl pipeCtrl (
      .bus(bus), .reset(reset), .decUop(decUop), .windowValid(windowValid),
      .rdUop(rdUop), .exUop(exUop), .retire(retire),
      .advance(advance), .halted(halted)
   );

   regFile regUnit (
      .bus(bus), .reset(reset), .decUop(decUop), .advance(advance), .retire(retire),
      .rdUop(rdUop), .srcVal(srcVal), .dstVal(dstVal)
   );

   aluStage aluUnit (
      .bus(bus), .reset(reset), .rdUop(rdUop), .srcVal(srcVal), .dstVal(dstVal),
      .exUop(exUop), .retire(retire)
   );
endmodule

// File: design/aluStage.sv
// results are plain 64-bit wraparound; no flags are produced
module aluStage (
   input  logic             bus,
   input  logic             reset,
   input  corePkg::uop_t    rdUop,
   input  corePkg::word_t   srcVal,
   input  corePkg::word_t   dstVal,
   output corePkg::uop_t    exUop,
   output corePkg::retire_t retire
);
   import corePkg::*;

   word_t result;
   word_t exValue;

   always_comb begin
      case (rdUop.kind)
         OpMov:   result = rdUop.imm;
         OpAdd:   result = dstVal + srcVal;
         OpSub:   result = dstVal - srcVal;
         default: result = dstVal;   // nop reports the unchanged dest
      endcase
   end

   always_ff @(posedge bus) begin
      exUop <= rdUop;
      exValue <= result;

      retire.valid <= exUop.valid;
      retire.regWrite <= writesReg(exUop.kind);
      retire.dest <= exUop.dest;
      retire.value <= exValue;
      retire.rip <= exUop.rip;

      if (reset) begin
         exUop.valid <= 1'b0;
         retire.valid <= 1'b0;
      end
   end
endmodule

// File: design/regFile.sv
// a retire write lands on the same edge the scoreboard clears, so no bypass is needed
module regFile (
   input  logic             bus,
   input  logic             reset,
   input  corePkg::uop_t    decUop,
   input  logic             advance,
   input  corePkg::retire_t retire,
   output corePkg::uop_t    rdUop,
   output corePkg::word_t   srcVal,
   output corePkg::word_t   dstVal
);
   import corePkg::*;

   word_t regs [RegCount];

   always_ff @(posedge bus) begin
      if (reset) begin
         for (int i = 0; i < RegCount; i++) begin
            regs[i] <= '0;
         end
      end else if (retire.valid && retire.regWrite) begin
         regs[retire.dest] <= retire.value;
      end
   end

   // read stage register
   always_ff @(posedge bus) begin
      rdUop <= decUop;
      rdUop.valid <= advance && decUop.valid && decUop.kind != OpHlt;   // HLT stops here
      srcVal <= regs[decUop.src];
      dstVal <= regs[decUop.dest];
      if (reset) begin
         rdUop.valid <= 1'b0;
      end
   end
endmodule

// File: design/pipeControl.sv
// one writer per register in flight; HLT leaves decode only once read and execute are empty
module pipeControl (
   input  logic             bus,
   input  logic             reset,
   input  corePkg::uop_t    decUop,
   input  logic             windowValid,
   input  corePkg::uop_t    rdUop,
   input  corePkg::uop_t    exUop,
   input  corePkg::retire_t retire,
   output logic             advance,
   output logic             halted
);
   import corePkg::*;

   typedef logic [RegCount-1:0] regMask_t;

   regMask_t busy;        // register has a pending writer
   regMask_t setMask;
   regMask_t clearMask;
   logic     destHazard;
   logic     srcHazard;
   logic     drained;
   logic     isHalt;

   always_comb begin
      isHalt = decUop.kind == OpHlt;
      destHazard = writesReg(decUop.kind) && busy[decUop.dest];
      srcHazard = decUop.srcValid && busy[decUop.src];
      drained = !rdUop.valid && !exUop.valid;   // older work is at writeback or done

      advance = windowValid && decUop.valid && !halted;
      if (destHazard || srcHazard) begin
         advance = 1'b0;
      end
      if (isHalt && !drained) begin
         advance = 1'b0;   // let the last retires show before halted
      end
   end

   always_comb begin
      setMask = '0;
      clearMask = '0;
      if (advance && writesReg(decUop.kind)) begin
         setMask = regMask_t'(1) << decUop.dest;
      end
      if (retire.valid && retire.regWrite) begin
         clearMask = regMask_t'(1) << retire.dest;
      end
   end

   always_ff @(posedge bus) begin
      if (reset) begin
         busy <= '0;
         halted <= 1'b0;
      end else begin
         busy <= (busy & ~clearMask) | setMask;
         if (advance && isHalt) begin
            halted <= 1'b1;   // held until reset
         end
      end
   end
endmodule

// File: design/instDecoder.sv
// unknown bytes, stray prefixes included, decode as one-byte NOPs; ADD/SUB need mod 11
module instDecoder (
   input  logic [corePkg::MaxInstBytes*8-1:0] window,
   input  corePkg::addr_t                     rip,
   output corePkg::uop_t                      uop,
   output corePkg::instLen_t                  byteCount
);
   import corePkg::*;

   logic [7:0] rex;
   logic [7:0] opc;
   logic [7:0] modrm;
   logic       rexW;
   logic       isMov;
   logic       isAlu;

   assign rex = window[7:0];
   assign opc = window[15:8];
   assign modrm = window[23:16];
   assign rexW = rex[7:4] == RexHigh && rex[3];

   assign isMov = rexW && opc[7:3] == OpcMovImm[7:3];
   assign isAlu = rexW && (opc == OpcAdd || opc == OpcSub) && modrm[7:6] == 2'b11;

   always_comb begin
      uop = '0;
      uop.valid = 1'b1;
      uop.kind = OpNop;
      uop.rip = rip;
      byteCount = instLen_t'(1);

      if (rex == OpcNop) begin
         uop.kind = OpNop;
      end else if (rex == OpcHlt) begin
         uop.kind = OpHlt;
      end else if (isMov) begin
         uop.kind = OpMov;
         uop.dest = {rex[0], opc[2:0]};   // REX.B picks r8..r15
         uop.imm = window[16 +: 64];      // little endian imm64
         byteCount = instLen_t'(MaxInstBytes);
      end else if (isAlu) begin
         uop.kind = (opc == OpcAdd) ? OpAdd : OpSub;
         uop.dest = {rex[0], modrm[2:0]};   // r/m is both operand and result
         uop.src = {rex[2], modrm[5:3]};
         uop.srcValid = 1'b1;
         byteCount = instLen_t'(3);
      end
   end
endmodule

// File: design/fetchBuffer.sv
// BufferBytes must be a power of two; below 128 a full line on top of 31 waiting bytes overruns it
module fetchBuffer #(
   parameter int BufferBytes = 128
) (
   input  logic                               bus,
   input  logic                               reset,
   input  corePkg::addr_t                     entry,
   input  logic                               advance,
   input  corePkg::instLen_t                  byteCount,
   output corePkg::busReq_t                   busReq,
   input  logic                               reqAck,
   input  corePkg::busResp_t                  busResp,
   output logic                               respAck,
   output logic [corePkg::MaxInstBytes*8-1:0] window,
   output logic                               windowValid,
   output corePkg::addr_t                     rip
);
   import corePkg::*;

   localparam int OffBits = $clog2(BufferBytes);
   localparam int SkipBits = $clog2(LineBytes);
   localparam int RefillLevel = 32;   // ask for the next line below this many bytes

   typedef logic [OffBits:0]    ptr_t;   // extra bit tells full from empty
   typedef logic [SkipBits-1:0] skip_t;

   fetchState_t state;
   logic        reqCyc;
   addr_t       fetchAddr;
   skip_t       skip;       // bytes of the first line before entry
   ptr_t        fillPtr;
   ptr_t        consPtr;
   ptr_t        count;
   logic [7:0]  buffer [BufferBytes];

   function automatic logic [OffBits-1:0] slot(input ptr_t base, input int delta);
      return OffBits'(int'(base) + delta);
   endfunction

   assign count = fillPtr - consPtr;
   assign windowValid = count >= ptr_t'(MaxInstBytes);
   assign respAck = busResp.cyc;   // never refuse a beat
   assign busReq = '{cyc: reqCyc, addr: fetchAddr, tag: ReadTag};

   always_comb begin
      for (int i = 0; i < MaxInstBytes; i++) begin
         window[i*8 +: 8] = buffer[slot(consPtr, i)];
      end
   end

   always_ff @(posedge bus) begin
      if (reset) begin
         state <= FetchIdle;
         reqCyc <= 1'b0;
         fetchAddr <= entry & ~addr_t'(LineBytes - 1);
         skip <= skip_t'(entry);
         fillPtr <= '0;
         consPtr <= '0;
         rip <= entry;
      end else begin
         reqCyc <= state == FetchIdle && !reqAck && count < ptr_t'(RefillLevel);
         if (busResp.cyc) begin
            state <= FetchActive;
            fetchAddr <= fetchAddr + addr_t'(BeatBytes);
            if (skip >= skip_t'(BeatBytes)) begin
               skip <= skip - skip_t'(BeatBytes);   // whole beat lies before entry
            end else begin
               skip <= '0;
               fillPtr <= fillPtr + ptr_t'(BeatBytes) - ptr_t'(skip);
            end
         end else if (state == FetchActive) begin
            state <= FetchIdle;   // burst over
         end else if (reqAck) begin
            state <= FetchWaiting;
         end
         if (advance) begin
            consPtr <= consPtr + ptr_t'(byteCount);
            rip <= rip + addr_t'(byteCount);
         end
      end
   end

   always_ff @(posedge bus) begin
      if (busResp.cyc && skip < skip_t'(BeatBytes)) begin
         for (int b = 0; b < BeatBytes; b++) begin
            if (b >= int'(skip)) begin
               buffer[slot(fillPtr, b - int'(skip))] <= busResp.data[b*8 +: 8];
            end
         end
      end
   end
endmodule

// File: design/corePkg.sv
// only NOP, HLT, MOV r64,imm64 and register-direct ADD/SUB exist; no flags are modelled
package corePkg;
   `include "coreDefs.svh"

   localparam int MaxInstBytes = 10;   // MOV r64,imm64 is the longest kept form

   typedef logic [63:0] addr_t;
   typedef logic [63:0] word_t;
   typedef logic [3:0]  regIdx_t;
   typedef logic [3:0]  instLen_t;   // instruction length in bytes
   typedef logic [12:0] busTag_t;

   localparam busTag_t ReadTag = {1'b1, 4'b0001, 8'h00};   // read, memory space

   localparam logic [7:0] OpcNop    = 8'h90;
   localparam logic [7:0] OpcHlt    = 8'hF4;
   localparam logic [7:0] OpcMovImm = 8'hB8;   // low 3 bits hold the register
   localparam logic [7:0] OpcAdd    = 8'h01;
   localparam logic [7:0] OpcSub    = 8'h29;
   localparam logic [3:0] RexHigh   = 4'h4;

   typedef enum logic [2:0] {OpNop, OpMov, OpAdd, OpSub, OpHlt} opKind_t;
   typedef enum logic [1:0] {FetchIdle, FetchWaiting, FetchActive} fetchState_t;

   typedef struct packed {
      logic    cyc;
      addr_t   addr;
      busTag_t tag;
   } busReq_t;

   typedef struct packed {
      logic  cyc;
      word_t data;
   } busResp_t;

   typedef struct packed {
      logic    valid;
      opKind_t kind;
      regIdx_t dest;
      regIdx_t src;
      logic    srcValid;
      word_t   imm;
      addr_t   rip;
   } uop_t;

   typedef struct packed {
      logic    valid;
      logic    regWrite;   // low for NOP, the register file is left alone
      regIdx_t dest;
      word_t   value;
      addr_t   rip;
   } retire_t;

   function automatic logic writesReg(input opKind_t kind);
      return kind inside {OpMov, OpAdd, OpSub};
   endfunction
endpackage

// File: include/coreDefs.svh
// sizes assume a 64-bit bus that moves 8 bytes per beat and 8 beats per line
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

localparam int LineBytes    = 64;   // bytes per bus line, fetch address aligned to this
localparam int BeatBytes    = 8;    // bytes carried by one response beat
localparam int RegCount     = 16;   // architectural registers rax..r15

`endif
